// File: vrf_pkg.sv
`default_nettype none

package vrf_pkg;

  //////////////////////////////////////////////////
  // Lane sizes
  //////////////////////////////////////////////////

  // Architectural vector registers in the lane
  localparam int unsigned NrVRegs = 32;

  //////////////////////////////////////////////////
  // Data types
  //////////////////////////////////////////////////

  // One word of a vector register
  typedef logic [63:0] elen_t;

  // Byte enables of one word
  typedef logic [7:0] strb_t;

  // Source register number
  typedef logic [4:0] vreg_t;

  // Element count of one operand request
  typedef logic [9:0] vlen_t;

  //////////////////////////////////////////////////
  // Enums
  //////////////////////////////////////////////////

  // Element width, a word holds 8 >> eew elements
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } eew_e;

  // State of one operand requester
  typedef enum logic {
    IDLE,
    REQUESTING
  } req_state_e;

endpackage

`default_nettype wire

// File: vrf_master_if.sv
`timescale 1ns/1ps
`default_nettype none

// One master's port into the bank crossbar
interface vrf_master_if #(
  parameter int unsigned AddrWidth = 8
);

  // Request fields, held stable while req is high
  logic                 req;
  logic [AddrWidth-1:0] addr;
  logic                 wen;
  vrf_pkg::elen_t       wdata;
  vrf_pkg::strb_t       be;

  // Same-cycle grant from the crossbar
  logic                 gnt;

  modport master (
    output req,
    output addr,
    output wen,
    output wdata,
    output be,
    input  gnt
  );

  modport xbar (
    input  req,
    input  addr,
    input  wen,
    input  wdata,
    input  be,
    output gnt
  );

endinterface

`default_nettype wire

// File: operand_requester.sv
`timescale 1ns/1ps
`default_nettype none

module operand_requester #(
  parameter  int unsigned NrBanks     = 4,
  parameter  int unsigned WordsPerReg = 8,
  localparam int unsigned AddrWidth   = $clog2(vrf_pkg::NrVRegs * WordsPerReg)
) (
  input  wire logic            clk_i,
  input  wire logic            rst_ni,
  // Command from the lane sequencer
  input  wire logic            cmd_valid_i,
  output logic                 cmd_ready_o,
  input  vrf_pkg::vreg_t       cmd_vreg_i,
  input  vrf_pkg::vlen_t       cmd_len_i,
  input  vrf_pkg::eew_e        cmd_eew_i,
  // Operand queue has room
  input  wire logic            operand_ready_i,
  // Read requests into the crossbar
  vrf_master_if.master         bus
);

  vrf_pkg::req_state_e  state_d, state_q;
  logic [AddrWidth-1:0] addr_d, addr_q;
  vrf_pkg::vlen_t       len_d, len_q;
  vrf_pkg::eew_e        eew_d, eew_q;

  logic                 grant;
  logic                 finish;
  vrf_pkg::vlen_t       elems_per_word;
  vrf_pkg::vlen_t       len_left;
  logic [AddrWidth-1:0] first_addr;

  //////////////////////////////////////////////////
  // Word accounting
  //////////////////////////////////////////////////

  assign elems_per_word = vrf_pkg::vlen_t'(8) >> eew_q;

  // Less than a full word left means this is the last word
  assign len_left = (len_q < elems_per_word) ? '0 : len_q - elems_per_word;

  assign first_addr = AddrWidth'(cmd_vreg_i * WordsPerReg);

  assign grant  = bus.req && bus.gnt;
  assign finish = grant && (len_left == '0);

  // Idle, or handing out the last word right now
  assign cmd_ready_o = cmd_valid_i && ((state_q == vrf_pkg::IDLE) || finish);

  // Reads only, the write fields stay quiet
  assign bus.req   = (state_q == vrf_pkg::REQUESTING) && operand_ready_i;
  assign bus.addr  = addr_q;
  assign bus.wen   = 1'b0;
  assign bus.wdata = '0;
  assign bus.be    = '0;

  //////////////////////////////////////////////////
  // Requester FSM
  //////////////////////////////////////////////////

  always_comb begin : p_next
    state_d = state_q;
    addr_d  = addr_q;
    len_d   = len_q;
    eew_d   = eew_q;

    if (grant) begin
      addr_d = addr_q + 1'b1;
      len_d  = len_left;
    end
    if (finish) begin
      state_d = vrf_pkg::IDLE;
    end

    // New command, a zero count is taken but muted
    if (cmd_ready_o) begin
      addr_d  = first_addr;
      len_d   = cmd_len_i;
      eew_d   = cmd_eew_i;
      state_d = (cmd_len_i == '0) ? vrf_pkg::IDLE : vrf_pkg::REQUESTING;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q <= vrf_pkg::IDLE;
      addr_q  <= '0;
      len_q   <= '0;
      eew_q   <= vrf_pkg::EW64;
    end else begin
      state_q <= state_d;
      addr_q  <= addr_d;
      len_q   <= len_d;
      eew_q   <= eew_d;
    end
  end

  // A pending request keeps pointing at the same word
  addr_stable_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (bus.req && !bus.gnt) |=> $stable(bus.addr));

  no_req_idle_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == vrf_pkg::IDLE) |-> !bus.req);

endmodule

`default_nettype wire

// File: vrf_xbar_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module vrf_xbar_arbiter #(
  parameter  int unsigned NrBanks      = 4,
  parameter  int unsigned NrReadPorts  = 2,
  parameter  int unsigned NrWritePorts = 2,
  parameter  int unsigned WordsPerReg  = 8,
  localparam int unsigned NrMasters    = NrReadPorts + NrWritePorts,
  localparam int unsigned AddrWidth    = $clog2(vrf_pkg::NrVRegs * WordsPerReg),
  localparam int unsigned BankBits     = $clog2(NrBanks),
  localparam int unsigned RowWidth     = AddrWidth - BankBits,
  localparam int unsigned TagWidth     = (NrReadPorts > 1) ? $clog2(NrReadPorts) : 1
) (
  input  wire logic                               clk_i,
  input  wire logic                               rst_ni,
  vrf_master_if.xbar                              masters [NrMasters],
  // Bank side
  output logic           [NrBanks-1:0]                bank_req_o,
  output logic           [NrBanks-1:0][RowWidth-1:0]  bank_row_o,
  output logic           [NrBanks-1:0]                bank_wen_o,
  output vrf_pkg::elen_t [NrBanks-1:0]                bank_wdata_o,
  output vrf_pkg::strb_t [NrBanks-1:0]                bank_be_o,
  output logic           [NrBanks-1:0][TagWidth-1:0]  bank_tag_o,
  input  wire logic      [NrBanks-1:0]                bank_rvalid_i,
  input  wire logic      [NrBanks-1:0][TagWidth-1:0]  bank_rtag_i,
  input  vrf_pkg::elen_t [NrBanks-1:0]                bank_rdata_i,
  // Operand queues
  output logic           [NrReadPorts-1:0]            operand_valid_o,
  output vrf_pkg::elen_t [NrReadPorts-1:0]            operand_o
);

  localparam int unsigned MIdxW = (NrMasters > 1) ? $clog2(NrMasters) : 1;

  logic                 m_req   [NrMasters];
  logic [AddrWidth-1:0] m_addr  [NrMasters];
  logic                 m_wen   [NrMasters];
  vrf_pkg::elen_t       m_wdata [NrMasters];
  vrf_pkg::strb_t       m_be    [NrMasters];
  logic [NrMasters-1:0] m_gnt;
  logic [NrMasters-1:0] bank_gnt [NrBanks];

  for (genvar m = 0; m < NrMasters; m++) begin : gen_master
    assign m_req[m]       = masters[m].req;
    assign m_addr[m]      = masters[m].addr;
    assign m_wen[m]       = masters[m].wen;
    assign m_wdata[m]     = masters[m].wdata;
    assign m_be[m]        = masters[m].be;
    assign masters[m].gnt = m_gnt[m];

    gnt_has_req_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
      masters[m].gnt |-> masters[m].req);
  end

  //////////////////////////////////////////////////
  // Per-bank round robin
  //////////////////////////////////////////////////

  for (genvar b = 0; b < NrBanks; b++) begin : gen_bank_arb
    logic [NrMasters-1:0] hit;
    logic [NrMasters-1:0] gnt;
    logic [MIdxW-1:0]     rr_q;
    logic [MIdxW-1:0]     win;
    logic                 found;

    // Low address bits select the bank
    for (genvar m = 0; m < NrMasters; m++) begin : gen_hit
      assign hit[m] = m_req[m] && (m_addr[m][BankBits-1:0] == BankBits'(b));
    end

    // First hit at or after the pointer wins
    always_comb begin : p_pick
      int unsigned idx;
      win   = '0;
      found = 1'b0;
      gnt   = '0;
      for (int unsigned i = 0; i < NrMasters; i++) begin
        idx = int'(rr_q) + i;
        if (idx >= NrMasters) begin
          idx = idx - NrMasters;
        end
        if (!found && hit[idx]) begin
          found = 1'b1;
          win   = MIdxW'(idx);
        end
      end
      if (found) begin
        gnt[win] = 1'b1;
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_rr
      if (!rst_ni) begin
        rr_q <= '0;
      end else if (found) begin
        rr_q <= (win == MIdxW'(NrMasters - 1)) ? '0 : win + 1'b1;
      end
    end

    assign bank_gnt[b]     = gnt;
    assign bank_req_o[b]   = found;
    assign bank_row_o[b]   = m_addr[win][AddrWidth-1:BankBits];
    assign bank_wen_o[b]   = m_wen[win];
    assign bank_wdata_o[b] = m_wdata[win];
    assign bank_be_o[b]    = m_be[win];
    // Read masters come first, so the index is the queue number
    assign bank_tag_o[b]   = TagWidth'(win);

    one_gnt_a : assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(gnt));
  end

  always_comb begin : p_master_gnt
    m_gnt = '0;
    for (int unsigned b = 0; b < NrBanks; b++) begin
      m_gnt = m_gnt | bank_gnt[b];
    end
  end

  //////////////////////////////////////////////////
  // Read return routing
  //////////////////////////////////////////////////

  // A queue reads one bank per cycle, so at most one return per queue
  always_comb begin : p_return
    operand_valid_o = '0;
    operand_o       = '0;
    for (int unsigned b = 0; b < NrBanks; b++) begin
      if (bank_rvalid_i[b]) begin
        operand_valid_o[bank_rtag_i[b]] = 1'b1;
        operand_o[bank_rtag_i[b]]       = bank_rdata_i[b];
      end
    end
  end

endmodule

`default_nettype wire

// File: vrf_bank.sv
`timescale 1ns/1ps
`default_nettype none

module vrf_bank #(
  parameter  int unsigned Rows     = 64,
  parameter  int unsigned TagWidth = 1,
  localparam int unsigned RowWidth = $clog2(Rows)
) (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                req_i,
  input  wire logic [RowWidth-1:0] row_i,
  input  wire logic                wen_i,
  input  vrf_pkg::elen_t           wdata_i,
  input  vrf_pkg::strb_t           be_i,
  input  wire logic [TagWidth-1:0] tag_i,
  output logic                     rvalid_o,
  output logic      [TagWidth-1:0] rtag_o,
  output vrf_pkg::elen_t           rdata_o
);

  vrf_pkg::elen_t mem [Rows];

  // Byte-enable write, and read data with its tag
  always_ff @(posedge clk_i) begin : p_mem
    if (req_i && wen_i) begin
      for (int unsigned i = 0; i < 8; i++) begin
        if (be_i[i]) begin
          mem[row_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
        end
      end
    end
    if (req_i && !wen_i) begin
      rdata_o <= mem[row_i];
      rtag_o  <= tag_i;
    end
  end

  // Valid for exactly one cycle per read
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rvalid
    if (!rst_ni) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i && !wen_i;
    end
  end

endmodule

`default_nettype wire

// File: vrf_lane.sv
`timescale 1ns/1ps
`default_nettype none

module vrf_lane #(
  parameter  int unsigned NrBanks      = 4,
  parameter  int unsigned WordsPerReg  = 8,
  parameter  int unsigned NrReadPorts  = 2,
  parameter  int unsigned NrWritePorts = 2,
  localparam int unsigned AddrWidth    = $clog2(vrf_pkg::NrVRegs * WordsPerReg)
) (
  input  wire logic                                   clk_i,
  input  wire logic                                   rst_ni,
  // Operand requesters
  input  wire logic      [NrReadPorts-1:0]            cmd_valid_i,
  output logic           [NrReadPorts-1:0]            cmd_ready_o,
  input  vrf_pkg::vreg_t [NrReadPorts-1:0]            cmd_vreg_i,
  input  vrf_pkg::vlen_t [NrReadPorts-1:0]            cmd_len_i,
  input  vrf_pkg::eew_e  [NrReadPorts-1:0]            cmd_eew_i,
  input  wire logic      [NrReadPorts-1:0]            operand_ready_i,
  output logic           [NrReadPorts-1:0]            operand_valid_o,
  output vrf_pkg::elen_t [NrReadPorts-1:0]            operand_o,
  // Result write ports
  input  wire logic      [NrWritePorts-1:0]           wr_req_i,
  input  wire logic      [NrWritePorts-1:0][AddrWidth-1:0] wr_addr_i,
  input  vrf_pkg::elen_t [NrWritePorts-1:0]           wr_wdata_i,
  input  vrf_pkg::strb_t [NrWritePorts-1:0]           wr_be_i,
  output logic           [NrWritePorts-1:0]           wr_gnt_o
);

  localparam int unsigned NrMasters = NrReadPorts + NrWritePorts;
  localparam int unsigned RowWidth  = AddrWidth - $clog2(NrBanks);
  localparam int unsigned Rows      = vrf_pkg::NrVRegs * WordsPerReg / NrBanks;
  localparam int unsigned TagWidth  = (NrReadPorts > 1) ? $clog2(NrReadPorts) : 1;

  // Read masters first, then the write ports
  vrf_master_if #(.AddrWidth(AddrWidth)) master_bus [NrMasters] ();

  logic           [NrBanks-1:0]               bank_req;
  logic           [NrBanks-1:0][RowWidth-1:0] bank_row;
  logic           [NrBanks-1:0]               bank_wen;
  vrf_pkg::elen_t [NrBanks-1:0]               bank_wdata;
  vrf_pkg::strb_t [NrBanks-1:0]               bank_be;
  logic           [NrBanks-1:0][TagWidth-1:0] bank_tag;
  logic           [NrBanks-1:0]               bank_rvalid;
  logic           [NrBanks-1:0][TagWidth-1:0] bank_rtag;
  vrf_pkg::elen_t [NrBanks-1:0]               bank_rdata;

  //////////////////////////////////////////////////
  // Masters
  //////////////////////////////////////////////////

  for (genvar r = 0; r < NrReadPorts; r++) begin : gen_requester
    operand_requester #(
      .NrBanks    (NrBanks),
      .WordsPerReg(WordsPerReg)
    ) i_requester (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .cmd_valid_i    (cmd_valid_i[r]),
      .cmd_ready_o    (cmd_ready_o[r]),
      .cmd_vreg_i     (cmd_vreg_i[r]),
      .cmd_len_i      (cmd_len_i[r]),
      .cmd_eew_i      (cmd_eew_i[r]),
      .operand_ready_i(operand_ready_i[r]),
      .bus            (master_bus[r])
    );
  end

  for (genvar w = 0; w < NrWritePorts; w++) begin : gen_write_port
    assign master_bus[NrReadPorts+w].req   = wr_req_i[w];
    assign master_bus[NrReadPorts+w].addr  = wr_addr_i[w];
    assign master_bus[NrReadPorts+w].wen   = 1'b1;
    assign master_bus[NrReadPorts+w].wdata = wr_wdata_i[w];
    assign master_bus[NrReadPorts+w].be    = wr_be_i[w];
    assign wr_gnt_o[w]                     = master_bus[NrReadPorts+w].gnt;
  end

  //////////////////////////////////////////////////
  // Crossbar and banks
  //////////////////////////////////////////////////

  vrf_xbar_arbiter #(
    .NrBanks     (NrBanks),
    .NrReadPorts (NrReadPorts),
    .NrWritePorts(NrWritePorts),
    .WordsPerReg (WordsPerReg)
  ) i_xbar (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .masters        (master_bus),
    .bank_req_o     (bank_req),
    .bank_row_o     (bank_row),
    .bank_wen_o     (bank_wen),
    .bank_wdata_o   (bank_wdata),
    .bank_be_o      (bank_be),
    .bank_tag_o     (bank_tag),
    .bank_rvalid_i  (bank_rvalid),
    .bank_rtag_i    (bank_rtag),
    .bank_rdata_i   (bank_rdata),
    .operand_valid_o(operand_valid_o),
    .operand_o      (operand_o)
  );

  for (genvar b = 0; b < NrBanks; b++) begin : gen_bank
    vrf_bank #(
      .Rows    (Rows),
      .TagWidth(TagWidth)
    ) i_bank (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (bank_req[b]),
      .row_i   (bank_row[b]),
      .wen_i   (bank_wen[b]),
      .wdata_i (bank_wdata[b]),
      .be_i    (bank_be[b]),
      .tag_i   (bank_tag[b]),
      .rvalid_o(bank_rvalid[b]),
      .rtag_o  (bank_rtag[b]),
      .rdata_o (bank_rdata[b])
    );
  end

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

// Free-running 4 ns clock and power-on reset
module tb_clk_gen #(
  parameter int unsigned ResetCycles = 3
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin : p_clk
    clk_o = 1'b0;
    forever begin
      #2 clk_o = ~clk_o;
    end
  end

  // Released just after the last reset edge
  initial begin : p_rst
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_vrf_lane.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vrf_lane;

  localparam int unsigned WordsPerReg  = 8;
  localparam int unsigned NrReadPorts  = 2;
  localparam int unsigned NrWritePorts = 2;
  localparam int unsigned AddrWidth    = 8;
  localparam int unsigned NrWords      = vrf_pkg::NrVRegs * WordsPerReg;
  localparam int unsigned MaxWords     = 128;
  localparam int unsigned Timeout      = 200;

  logic clk;
  logic rst_n;

  logic           [NrReadPorts-1:0]                 cmd_valid;
  logic           [NrReadPorts-1:0]                 cmd_ready;
  vrf_pkg::vreg_t [NrReadPorts-1:0]                 cmd_vreg;
  vrf_pkg::vlen_t [NrReadPorts-1:0]                 cmd_len;
  vrf_pkg::eew_e  [NrReadPorts-1:0]                 cmd_eew;
  logic           [NrReadPorts-1:0]                 operand_ready;
  logic           [NrReadPorts-1:0]                 operand_valid;
  vrf_pkg::elen_t [NrReadPorts-1:0]                 operand;
  logic           [NrWritePorts-1:0]                wr_req;
  logic           [NrWritePorts-1:0][AddrWidth-1:0] wr_addr;
  vrf_pkg::elen_t [NrWritePorts-1:0]                wr_wdata;
  vrf_pkg::strb_t [NrWritePorts-1:0]                wr_be;
  logic           [NrWritePorts-1:0]                wr_gnt;

  // Reference copy of the whole register file
  vrf_pkg::elen_t model [NrWords];

  // Every word seen per queue, and where the current command starts
  vrf_pkg::elen_t got_data [NrReadPorts][MaxWords];
  int unsigned    got_cnt  [NrReadPorts];
  int unsigned    got_base [NrReadPorts];

  logic [31:0] lfsr_q;

  tb_clk_gen i_clk_gen (
    .clk_o (clk),
    .rst_no(rst_n)
  );

  vrf_lane uut (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .cmd_valid_i    (cmd_valid),
    .cmd_ready_o    (cmd_ready),
    .cmd_vreg_i     (cmd_vreg),
    .cmd_len_i      (cmd_len),
    .cmd_eew_i      (cmd_eew),
    .operand_ready_i(operand_ready),
    .operand_valid_o(operand_valid),
    .operand_o      (operand),
    .wr_req_i       (wr_req),
    .wr_addr_i      (wr_addr),
    .wr_wdata_i     (wr_wdata),
    .wr_be_i        (wr_be),
    .wr_gnt_o       (wr_gnt)
  );

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      stop_with_error($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_word(output vrf_pkg::elen_t w);
    w = '0;
    for (int i = 0; i < 64; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      w      = {w[62:0], lfsr_q[31]};
    end
  endtask

  function automatic vrf_pkg::elen_t byte_mask(input vrf_pkg::strb_t be);
    vrf_pkg::elen_t m;
    for (int i = 0; i < 8; i++) begin
      m[i*8 +: 8] = {8{be[i]}};
    end
    return m;
  endfunction

  function automatic vrf_pkg::elen_t fill_pattern(input int unsigned addr);
    return 64'h0123_4567_89ab_cdef ^ {8{8'(addr)}};
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Sample mid-cycle, after the inputs and the registers have settled
  always @(negedge clk) begin : p_monitor
    vrf_pkg::elen_t mask;
    if (rst_n) begin
      for (int w = 0; w < NrWritePorts; w++) begin
        if (wr_req[w] && wr_gnt[w]) begin
          mask                = byte_mask(wr_be[w]);
          model[wr_addr[w]]   = (model[wr_addr[w]] & ~mask) | (wr_wdata[w] & mask);
        end
      end
      for (int q = 0; q < NrReadPorts; q++) begin
        if (operand_valid[q]) begin
          if (got_cnt[q] < MaxWords) begin
            got_data[q][got_cnt[q]] = operand[q];
          end
          got_cnt[q]++;
        end
      end
    end
  end

  task automatic write_word(input int unsigned port, input int unsigned addr,
                            input vrf_pkg::elen_t data, input vrf_pkg::strb_t be);
    int unsigned cycles;
    next_cycle();
    wr_req[port]   = 1'b1;
    wr_addr[port]  = AddrWidth'(addr);
    wr_wdata[port] = data;
    wr_be[port]    = be;
    cycles         = 0;
    @(negedge clk);
    while (!wr_gnt[port]) begin
      cycles++;
      if (cycles > Timeout) begin
        stop_with_error($sformatf("write port %0d was never granted", port));
      end
      @(negedge clk);
    end
    next_cycle();
    wr_req[port] = 1'b0;
  endtask

  task automatic issue_cmd(input int unsigned q, input int unsigned vreg,
                           input int unsigned len, input vrf_pkg::eew_e eew);
    int unsigned cycles;
    next_cycle();
    got_base[q]  = got_cnt[q];
    cmd_valid[q] = 1'b1;
    cmd_vreg[q]  = vrf_pkg::vreg_t'(vreg);
    cmd_len[q]   = vrf_pkg::vlen_t'(len);
    cmd_eew[q]   = eew;
    cycles       = 0;
    @(negedge clk);
    while (!cmd_ready[q]) begin
      cycles++;
      if (cycles > Timeout) begin
        stop_with_error($sformatf("queue %0d did not accept its command", q));
      end
      @(negedge clk);
    end
    next_cycle();
    cmd_valid[q] = 1'b0;
  endtask

  // Wait for n words, stay quiet a while, then compare against the model
  task automatic expect_words(input int unsigned q, input int unsigned base,
                              input int unsigned n, input int unsigned quiet);
    int unsigned cycles;
    cycles = 0;
    while (got_cnt[q] - got_base[q] < n) begin
      cycles++;
      if (cycles > Timeout) begin
        stop_with_error($sformatf("queue %0d got only %0d of %0d words",
                                  q, got_cnt[q] - got_base[q], n));
      end
      next_cycle();
    end
    repeat (quiet) next_cycle();
    check_eq($sformatf("operand word count q%0d", q), 64'(got_cnt[q] - got_base[q]), 64'(n));
    for (int unsigned k = 0; k < n; k++) begin
      check_eq($sformatf("operand_o[%0d] word %0d", q, k),
               got_data[q][got_base[q] + k], model[base + k]);
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_write_read_back();
    vrf_pkg::elen_t data;
    for (int unsigned a = WordsPerReg; a < 3 * WordsPerReg; a++) begin
      random_word(data);
      write_word(0, a, data, 8'hff);
    end
    issue_cmd(0, 1, 8, vrf_pkg::EW64);
    expect_words(0, 1 * WordsPerReg, 8, 2);
    issue_cmd(0, 2, 8, vrf_pkg::EW64);
    expect_words(0, 2 * WordsPerReg, 8, 2);
  endtask

  task automatic test_partial_write();
    vrf_pkg::strb_t be_list [8] = '{8'h0f, 8'hf0, 8'ha5, 8'h01, 8'h80, 8'h3c, 8'h00, 8'hff};
    vrf_pkg::elen_t exp_words [8];
    vrf_pkg::elen_t data;
    int unsigned    base;
    base = 3 * WordsPerReg;
    for (int unsigned k = 0; k < 8; k++) begin
      write_word(1, base + k, fill_pattern(base + k), 8'hff);
    end
    for (int unsigned k = 0; k < 8; k++) begin
      random_word(data);
      exp_words[k] = (fill_pattern(base + k) & ~byte_mask(be_list[k]))
                   | (data & byte_mask(be_list[k]));
      write_word(1, base + k, data, be_list[k]);
    end
    issue_cmd(1, 3, 8, vrf_pkg::EW64);
    expect_words(1, base, 8, 2);
    for (int unsigned k = 0; k < 8; k++) begin
      check_eq($sformatf("operand_o[1] merged word %0d", k),
               got_data[1][got_base[1] + k], exp_words[k]);
    end
  endtask

  task automatic test_word_count();
    issue_cmd(0, 1, 5, vrf_pkg::EW16);
    expect_words(0, WordsPerReg, 2, 20);
    issue_cmd(0, 1, 3, vrf_pkg::EW8);
    expect_words(0, WordsPerReg, 1, 20);
    issue_cmd(0, 1, 8, vrf_pkg::EW32);
    expect_words(0, WordsPerReg, 4, 20);
  endtask

  task automatic test_zero_length();
    issue_cmd(1, 2, 0, vrf_pkg::EW32);
    repeat (20) next_cycle();
    check_eq("operand_valid_o[1] count", 64'(got_cnt[1] - got_base[1]), 64'd0);
    // The requester is idle again and takes the next command at once
    got_base[1]  = got_cnt[1];
    cmd_valid[1] = 1'b1;
    cmd_vreg[1]  = vrf_pkg::vreg_t'(2);
    cmd_len[1]   = vrf_pkg::vlen_t'(8);
    cmd_eew[1]   = vrf_pkg::EW64;
    @(negedge clk);
    check_eq("cmd_ready_o[1]", 64'(cmd_ready[1]), 64'd1);
    next_cycle();
    cmd_valid[1] = 1'b0;
    expect_words(1, 2 * WordsPerReg, 8, 2);
  endtask

  task automatic test_shared_reads();
    fork
      begin
        issue_cmd(0, 1, 8, vrf_pkg::EW64);
        expect_words(0, WordsPerReg, 8, 4);
      end
      begin
        issue_cmd(1, 1, 16, vrf_pkg::EW64);
        expect_words(1, WordsPerReg, 16, 4);
      end
    join
  endtask

  task automatic test_backpressure();
    vrf_pkg::elen_t data0;
    vrf_pkg::elen_t data1;
    int unsigned    cycles;
    int unsigned    at_drop;
    random_word(data0);
    random_word(data1);
    issue_cmd(0, 2, 8, vrf_pkg::EW64);
    cycles = 0;
    while (got_cnt[0] - got_base[0] < 3) begin
      cycles++;
      if (cycles > Timeout) begin
        stop_with_error("queue 0 made no progress before the back-pressure step");
      end
      next_cycle();
    end
    operand_ready[0] = 1'b0;
    at_drop          = got_cnt[0];
    // Words 1 and 5 of register 3 both live in bank 1
    fork
      repeat (10) next_cycle();
      write_word(0, 3 * WordsPerReg + 1, data0, 8'hff);
      write_word(1, 3 * WordsPerReg + 5, data1, 8'hff);
    join
    if (got_cnt[0] > at_drop + 1) begin
      stop_with_error($sformatf("queue 0 received %0d words while operand_ready_i was low",
                                got_cnt[0] - at_drop));
    end
    operand_ready[0] = 1'b1;
    expect_words(0, 2 * WordsPerReg, 8, 2);
    issue_cmd(1, 3, 8, vrf_pkg::EW64);
    expect_words(1, 3 * WordsPerReg, 8, 2);
    check_eq("operand_o[1] word 1", got_data[1][got_base[1] + 1], data0);
    check_eq("operand_o[1] word 5", got_data[1][got_base[1] + 5], data1);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin : p_main
    int unsigned cycles;
    lfsr_q        = 32'hcdeb_ca29;
    cmd_valid     = '0;
    cmd_vreg      = '0;
    cmd_len       = '0;
    operand_ready = '1;
    wr_req        = '0;
    wr_addr       = '0;
    wr_wdata      = '0;
    wr_be         = '0;
    for (int q = 0; q < NrReadPorts; q++) begin
      cmd_eew[q]  = vrf_pkg::EW64;
      got_cnt[q]  = 0;
      got_base[q] = 0;
    end

    cycles = 0;
    while (rst_n !== 1'b1) begin
      cycles++;
      if (cycles > Timeout) begin
        stop_with_error("reset was never released");
      end
      @(posedge clk);
    end
    next_cycle();
    check_eq("cmd_ready_o", 64'(cmd_ready), 64'd0);
    check_eq("operand_valid_o", 64'(operand_valid), 64'd0);
    check_eq("wr_gnt_o", 64'(wr_gnt), 64'd0);

    test_write_read_back();
    test_partial_write();
    test_word_count();
    test_zero_length();
    test_shared_reads();
    test_backpressure();

    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
vrf_pkg.sv
vrf_master_if.sv
operand_requester.sv
vrf_xbar_arbiter.sv
vrf_bank.sv
vrf_lane.sv
tb_clk_gen.sv
tb_vrf_lane.sv

// File: Bender.yml
package:
  name: vrf_lane

sources:
  - vrf_pkg.sv
  - vrf_master_if.sv
  - operand_requester.sv
  - vrf_xbar_arbiter.sv
  - vrf_bank.sv
  - vrf_lane.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_vrf_lane.sv
